/* hw/fpmul_settings.svh */
`ifndef FPMUL_SETTINGS_SVH
`define FPMUL_SETTINGS_SVH

// Binary32 word layout
`define FP_WIDTH     32
`define FP_EXP_W     8
`define FP_FRAC_W    23
`define FP_BIAS      127

// Radix-4 digits needed for a zero-extended 24-bit multiplier
`define BOOTH_DIGITS 13

// Canonical quiet NaN returned for every invalid product
`define FP_QNAN      32'h7fc00000

`endif

/* hw/fp_format_pkg.sv */
`include "fpmul_settings.svh"

package fp_format_pkg;

    // One binary32 word split into its fields
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp_fields_t;

    // The same word, taken whole or by field
    typedef union packed {
        logic [`FP_WIDTH-1:0] bits;
        fp_fields_t           fields;
    } fp_word_u;

    // Operand class once subnormals are flushed
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fp_class_t;

    function automatic fp_class_t fp_classify(fp_word_u w);
        fp_class_t c;
        // Zero exponent covers true zeros and flushed subnormals alike
        c.is_zero = (w.fields.exp == '0);
        // All-ones exponent splits on the fraction
        c.is_inf  = (&w.fields.exp) && (w.fields.frac == '0);
        c.is_nan  = (&w.fields.exp) && (w.fields.frac != '0);
        return c;
    endfunction

endpackage

/* hw/fpmul_stage_pkg.sv */
`include "fpmul_settings.svh"

package fpmul_stage_pkg;

    // Rounding modes in r_mode coding
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } round_mode_e;

    // Exception flags reported with each result
    typedef struct packed {
        logic zer;
        logic inf;
        logic nan;
        logic ovrf;
        logic udrf;
    } fp_flags_t;

    // Operand words and mode held by the requester during a request
    typedef struct packed {
        fp_format_pkg::fp_word_u x;
        fp_format_pkg::fp_word_u y;
        round_mode_e             rmode;
    } mul_op_t;

    // Normalized mantissa
    // Bit 26 leading one, 25:3 fraction, 2 guard, 1:0 round and sticky
    typedef struct packed {
        logic [`FP_FRAC_W+3:0] mant;
        logic                  norm_n;
        logic                  sign;
    } norm_result_t;

    // Rounded fraction and its carry out
    typedef struct packed {
        logic [`FP_FRAC_W-1:0] frac;
        logic                  norm_r;
    } round_result_t;

endpackage

/* hw/booth_step_counter.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module booth_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic last_digit
);

    localparam int CNT_W = $clog2(`BOOTH_DIGITS);

    // Digits still to come after the one in progress
    logic [CNT_W-1:0] remaining;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (load) begin
            // First digit is consumed on the step after load
            remaining <= CNT_W'(`BOOTH_DIGITS - 1);
        end else if (step && (remaining != '0)) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Final digit is a step with nothing left behind it
    assign last_digit = step && (remaining == '0);

endmodule

/* hw/fpmul_control.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fpmul_control (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic last_digit,
    output logic load,
    output logic step,
    output logic start_mul,
    output logic finish,
    output logic ack
);

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        ACCUM,
        FINISH,
        DONE
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // Wait for a new request
            IDLE: begin
                if (req) begin
                    state_next = CAPTURE;
                end
            end
            // Significands latched and digit count loaded
            CAPTURE: state_next = ACCUM;
            // One Booth digit per cycle
            ACCUM: begin
                if (last_digit) begin
                    state_next = FINISH;
                end
            end
            // Product settled, result registered
            FINISH: state_next = DONE;
            // Hold ack until the requester lets go
            DONE: begin
                if (!req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Stage enables decoded straight from the state
    assign load      = (state == CAPTURE);
    assign start_mul = (state == CAPTURE);
    assign step      = (state == ACCUM);
    assign finish    = (state == FINISH);
    assign ack       = (state == DONE);

endmodule

/* hw/booth_multiplier.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module booth_multiplier (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_mul,
    input  logic                          step,
    input  fpmul_stage_pkg::mul_op_t      op,
    output logic [2*`FP_FRAC_W+1:0]       product
);

    localparam int SIG_W  = `FP_FRAC_W + 1;
    localparam int PROD_W = 2 * SIG_W;
    // Two zero bits on top plus the implicit zero below bit 0
    localparam int MPLR_W = 2 * `BOOTH_DIGITS + 1;

    logic [SIG_W-1:0]  sig_x;
    logic [SIG_W-1:0]  sig_y;
    logic [SIG_W-1:0]  mcand;
    logic [MPLR_W-1:0] mplier;
    logic [PROD_W-1:0] acc;
    logic [PROD_W-1:0] pp;
    logic [2:0]        digit_bits;

    // Hidden bit set only for a nonzero exponent
    // so a subnormal operand yields a zero product
    assign sig_x = {|op.x.fields.exp, op.x.fields.frac};
    assign sig_y = {|op.y.fields.exp, op.y.fields.frac};

    // Digits are taken most significant first
    assign digit_bits = mplier[MPLR_W-1 -: 3];

    // Radix-4 recoding into 0, +-1 or +-2 times the multiplicand
    always_comb begin
        case (digit_bits)
            3'b001, 3'b010: pp = PROD_W'(mcand);
            3'b011:         pp = PROD_W'({mcand, 1'b0});
            3'b100:         pp = -PROD_W'({mcand, 1'b0});
            3'b101, 3'b110: pp = -PROD_W'(mcand);
            default:        pp = '0;
        endcase
    end

    // Operand registers
    always_ff @(posedge clk) begin
        if (start_mul) begin
            mcand  <= sig_x;
            mplier <= {{(MPLR_W-SIG_W-1){1'b0}}, sig_y, 1'b0};
        end else if (step) begin
            mplier <= {mplier[MPLR_W-3:0], 2'b00};
        end
    end

    // Accumulator shifts up two places and adds the new partial product
    // Modulo 2^48 arithmetic is enough since the final product fits
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (start_mul) begin
            acc <= '0;
        end else if (step) begin
            acc <= {acc[PROD_W-3:0], 2'b00} + pp;
        end
    end

    assign product = acc;

endmodule

/* hw/fpmul_normalize_round.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fpmul_normalize_round (
    input  logic [2*`FP_FRAC_W+1:0]        product,
    input  fpmul_stage_pkg::mul_op_t       op,
    output fpmul_stage_pkg::norm_result_t  norm,
    output fpmul_stage_pkg::round_result_t rnd
);

    import fpmul_stage_pkg::*;

    localparam int PROD_W   = 2 * (`FP_FRAC_W + 1);
    localparam int MANT_W   = `FP_FRAC_W + 4;
    // Low product bits folded into the sticky bit
    localparam int STICKY_W = PROD_W - MANT_W + 1;

    logic                  norm_n;
    logic                  sign;
    logic [PROD_W-1:0]     shifted;
    logic [MANT_W-1:0]     mant;
    logic                  lsb;
    logic                  guard;
    logic                  rest;
    logic                  inexact;
    logic                  inc;
    logic [`FP_FRAC_W:0]   frac_sum;

    // Product of two significands lies in [1,4)
    // a set top bit means it is already in [2,4)
    assign norm_n  = product[PROD_W-1];
    assign shifted = norm_n ? product : {product[PROD_W-2:0], 1'b0};

    // Upper 26 bits kept, the rest collapse into sticky
    assign mant = {shifted[PROD_W-1 -: MANT_W-1], |shifted[STICKY_W-1:0]};

    assign sign = op.x.fields.sign ^ op.y.fields.sign;

    assign norm.mant   = mant;
    assign norm.norm_n = norm_n;
    assign norm.sign   = sign;

    // Rounding inputs
    assign lsb     = mant[3];
    assign guard   = mant[2];
    assign rest    = |mant[1:0];
    assign inexact = guard | rest;

    always_comb begin
        case (op.rmode)
            // Above half, or exactly half with an odd fraction
            RM_RNE:  inc = guard & (rest | lsb);
            RM_RTZ:  inc = 1'b0;
            // Toward minus infinity grows negative magnitudes only
            RM_RDN:  inc = sign & inexact;
            RM_RUP:  inc = ~sign & inexact;
            // Ties away from zero
            RM_RMM:  inc = guard;
            default: inc = 1'b0;
        endcase
    end

    // Extra top bit catches the carry out of an all-ones fraction
    assign frac_sum = {1'b0, mant[MANT_W-2:3]} + {{`FP_FRAC_W{1'b0}}, inc};

    assign rnd.frac   = frac_sum[`FP_FRAC_W-1:0];
    assign rnd.norm_r = frac_sum[`FP_FRAC_W];

endmodule

/* hw/fpmul_exponent.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fpmul_exponent (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           finish,
    input  fpmul_stage_pkg::mul_op_t       op,
    input  fpmul_stage_pkg::norm_result_t  norm,
    input  fpmul_stage_pkg::round_result_t rnd,
    output fp_format_pkg::fp_word_u        result,
    output fpmul_stage_pkg::fp_flags_t     flags
);

    import fp_format_pkg::*;
    import fpmul_stage_pkg::*;

    // Two spare bits hold the sign and range of the raw sum
    localparam int SUM_W = `FP_EXP_W + 2;
    localparam logic [`FP_EXP_W-1:0] EXP_MAX = '1;

    fp_class_t        cls_x;
    fp_class_t        cls_y;
    logic             any_special;
    logic             inf_times_zero;
    logic [SUM_W-1:0] exp_sum;
    logic             sum_le_zero;
    logic             sum_ge_max;
    fp_flags_t        flags_next;
    fp_word_u         result_next;

    assign cls_x = fp_classify(op.x);
    assign cls_y = fp_classify(op.y);

    // Bias removed once, plus one for a normalize or rounding carry
    assign exp_sum = SUM_W'(op.x.fields.exp) + SUM_W'(op.y.fields.exp)
                   - SUM_W'(`FP_BIAS) + SUM_W'(norm.norm_n | rnd.norm_r);

    assign sum_le_zero = exp_sum[SUM_W-1] || (exp_sum == '0);
    assign sum_ge_max  = !exp_sum[SUM_W-1] && (exp_sum >= SUM_W'(EXP_MAX));

    always_comb begin
        // Range flags only make sense for two finite nonzero operands
        any_special = cls_x.is_zero || cls_x.is_inf || cls_x.is_nan
                   || cls_y.is_zero || cls_y.is_inf || cls_y.is_nan;
        flags_next.ovrf = !any_special && sum_ge_max;
        flags_next.udrf = !any_special && sum_le_zero;

        // Result class in priority order
        inf_times_zero = (cls_x.is_inf && cls_y.is_zero) || (cls_y.is_inf && cls_x.is_zero);
        flags_next.nan = cls_x.is_nan || cls_y.is_nan || inf_times_zero;
        flags_next.inf = !flags_next.nan
                      && (cls_x.is_inf || cls_y.is_inf || flags_next.ovrf);
        flags_next.zer = !flags_next.nan && !flags_next.inf
                      && (cls_x.is_zero || cls_y.is_zero || flags_next.udrf);

        result_next.fields.sign = norm.sign;
        if (flags_next.nan) begin
            result_next.bits = `FP_QNAN;
        end else if (flags_next.inf) begin
            result_next.fields.exp  = '1;
            result_next.fields.frac = '0;
        end else if (flags_next.zer) begin
            result_next.fields.exp  = '0;
            result_next.fields.frac = '0;
        end else begin
            result_next.fields.exp  = exp_sum[`FP_EXP_W-1:0];
            result_next.fields.frac = rnd.frac;
        end
    end

    // Outputs hold until the next finish
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
        end else if (finish) begin
            result <= result_next;
            flags  <= flags_next;
        end
    end

endmodule

/* hw/fp_multiplier.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fp_multiplier (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  fpmul_stage_pkg::mul_op_t   op,
    output logic                       ack,
    output fp_format_pkg::fp_word_u    result,
    output fpmul_stage_pkg::fp_flags_t flags
);

    import fpmul_stage_pkg::*;

    logic                    load;
    logic                    step;
    logic                    start_mul;
    logic                    finish;
    logic                    last_digit;
    logic [2*`FP_FRAC_W+1:0] product;
    norm_result_t            norm;
    round_result_t           rnd;

    // Handshake and stage sequencing
    fpmul_control u_control (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .last_digit (last_digit),
        .load       (load),
        .step       (step),
        .start_mul  (start_mul),
        .finish     (finish),
        .ack        (ack)
    );

    // Counts the Booth digits left
    booth_step_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .last_digit (last_digit)
    );

    booth_multiplier u_booth (
        .clk        (clk),
        .rst        (rst),
        .start_mul  (start_mul),
        .step       (step),
        .op         (op),
        .product    (product)
    );

    fpmul_normalize_round u_norm_round (
        .product    (product),
        .op         (op),
        .norm       (norm),
        .rnd        (rnd)
    );

    // Exponent, exceptions and the result register
    fpmul_exponent u_exponent (
        .clk        (clk),
        .rst        (rst),
        .finish     (finish),
        .op         (op),
        .norm       (norm),
        .rnd        (rnd),
        .result     (result),
        .flags      (flags)
    );

endmodule

/* verification/fp_mul_checker.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fp_mul_checker (
    input  logic                           clk,
    input  logic                           finish,
    input  fpmul_stage_pkg::mul_op_t       op,
    input  logic [2*`FP_FRAC_W+1:0]        product,
    input  fpmul_stage_pkg::norm_result_t  norm,
    input  fpmul_stage_pkg::round_result_t rnd,
    input  logic [`FP_EXP_W+1:0]           exp_sum,
    output int                             errors
);

    import fpmul_stage_pkg::*;

    localparam int PW = 2 * (`FP_FRAC_W + 1);
    localparam int MW = `FP_FRAC_W + 4;

    int                   count = 0;
    logic [PW-1:0]        exact;
    logic [PW-1:0]        shifted;
    logic [MW-1:0]        mant_ref;
    logic                 sign_ref;
    logic [2:0]           tail;
    logic                 up;
    logic [`FP_FRAC_W:0]  frac_ref;
    logic [`FP_EXP_W+1:0] sum_ref;

    assign errors = count;

    // Stage values are settled for the whole FINISH cycle
    always @(negedge clk) begin
        if (finish) begin
            // Booth result against a plain multiply of the same significands
            exact = {{(`FP_FRAC_W+1){1'b0}}, |op.x.fields.exp, op.x.fields.frac}
                  * {{(`FP_FRAC_W+1){1'b0}}, |op.y.fields.exp, op.y.fields.frac};
            if (product != exact) begin
                $display("FAIL %0t: booth product %h, expected %h", $time, product, exact);
                count++;
            end

            // Normalization flag and one-place shift
            if (norm.norm_n != product[PW-1]) begin
                $display("FAIL %0t: norm_n %b for product %h", $time, norm.norm_n, product);
                count++;
            end
            shifted  = product[PW-1] ? product : product << 1;
            mant_ref = {shifted[PW-1 -: MW-1], |shifted[PW-MW:0]};
            sign_ref = op.x.fields.sign ^ op.y.fields.sign;
            if (norm.mant != mant_ref || norm.sign != sign_ref) begin
                $display("FAIL %0t: mantissa %h sign %b, expected %h", $time,
                         norm.mant, norm.sign, mant_ref);
                count++;
            end

            // Three discarded bits of the expected mantissa weighed against one half
            tail = mant_ref[2:0];
            case (op.rmode)
                RM_RNE:  up = (tail > 3'd4) || (tail == 3'd4 && mant_ref[3]);
                RM_RTZ:  up = 1'b0;
                RM_RDN:  up = sign_ref && (tail != 3'b000);
                RM_RUP:  up = !sign_ref && (tail != 3'b000);
                RM_RMM:  up = (tail >= 3'd4);
                default: up = 1'b0;
            endcase
            frac_ref = {1'b0, mant_ref[MW-2:3]} + {{`FP_FRAC_W{1'b0}}, up};
            if (rnd != {frac_ref[`FP_FRAC_W-1:0], frac_ref[`FP_FRAC_W]}) begin
                $display("FAIL %0t: rounded %h carry %b, expected %h", $time,
                         rnd.frac, rnd.norm_r, frac_ref);
                count++;
            end

            // Biased sum less one bias, plus a normalize or rounding carry
            sum_ref = {2'b00, op.x.fields.exp} + {2'b00, op.y.fields.exp}
                    - (`FP_EXP_W+2)'(`FP_BIAS)
                    + {{(`FP_EXP_W+1){1'b0}}, exact[PW-1] | frac_ref[`FP_FRAC_W]};
            if (exp_sum != sum_ref) begin
                $display("FAIL %0t: exponent sum %h, expected %h", $time, exp_sum, sum_ref);
                count++;
            end
        end
    end

endmodule

/* verification/fp_mul_tb.sv */
`timescale 1ns/100ps
`include "fpmul_settings.svh"

module fp_mul_tb;

    import fp_format_pkg::*;
    import fpmul_stage_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int LATENCY     = 15;
    localparam int N_REQUESTS  = 460;
    // Each request fits in 20 clocks, plus room for reset
    localparam int WATCHDOG_NS = N_REQUESTS * 20 * CLK_PERIOD + 200 * CLK_PERIOD;

    // Flag patterns as {zer, inf, nan, ovrf, udrf}
    localparam fp_flags_t FL_NONE = 5'b00000;
    localparam fp_flags_t FL_ZER  = 5'b10000;
    localparam fp_flags_t FL_INF  = 5'b01000;
    localparam fp_flags_t FL_NAN  = 5'b00100;
    localparam fp_flags_t FL_OVF  = 5'b01010;
    localparam fp_flags_t FL_UDF  = 5'b10001;

    typedef struct packed {
        logic [`FP_WIDTH-1:0] bits;
        fp_flags_t            flags;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 req;
    mul_op_t              op;
    logic                 ack;
    fp_word_u             result;
    fp_flags_t            flags;
    int                   tb_errors = 0;
    int                   chk_errors;
    int                   seed = 32'hd427;
    logic [`FP_WIDTH-1:0] got_bits;
    fp_flags_t            got_flags;

    fp_multiplier dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .ack    (ack),
        .result (result),
        .flags  (flags)
    );

    // Watches the internal stages on every finish
    fp_mul_checker u_checker (
        .clk     (clk),
        .finish  (dut.finish),
        .op      (dut.op),
        .product (dut.product),
        .norm    (dut.norm),
        .rnd     (dut.rnd),
        .exp_sum (dut.u_exponent.exp_sum),
        .errors  (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model straight from the IEEE-754 rules
    function automatic expect_t model_mul(logic [31:0] x, logic [31:0] y, round_mode_e rm);
        expect_t     e;
        logic        s;
        logic        zx;
        logic        zy;
        logic        ix;
        logic        iy;
        logic        nx;
        logic        ny;
        logic        special;
        logic [47:0] p;
        logic [47:0] sh;
        logic [26:0] m;
        logic        up;
        logic [23:0] f;
        int          ex;
        s  = x[31] ^ y[31];
        // Subnormals count as zero
        zx = (x[30:23] == 8'h00);
        zy = (y[30:23] == 8'h00);
        ix = (x[30:23] == 8'hff) && (x[22:0] == 23'd0);
        iy = (y[30:23] == 8'hff) && (y[22:0] == 23'd0);
        nx = (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
        ny = (y[30:23] == 8'hff) && (y[22:0] != 23'd0);
        p  = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
        sh = p[47] ? p : {p[46:0], 1'b0};
        m  = {sh[47:22], |sh[21:0]};
        // Three discarded bits compared with one half
        case (rm)
            RM_RNE:  up = (m[2:0] > 3'd4) || (m[2:0] == 3'd4 && m[3]);
            RM_RTZ:  up = 1'b0;
            RM_RDN:  up = s && (m[2:0] != 3'd0);
            RM_RUP:  up = !s && (m[2:0] != 3'd0);
            RM_RMM:  up = (m[2:0] >= 3'd4);
            default: up = 1'b0;
        endcase
        f  = {1'b0, m[25:3]} + {23'd0, up};
        ex = int'(x[30:23]) + int'(y[30:23]) - `FP_BIAS + ((p[47] || f[23]) ? 1 : 0);
        special      = zx || zy || ix || iy || nx || ny;
        e.flags.ovrf = !special && (ex >= 255);
        e.flags.udrf = !special && (ex <= 0);
        e.flags.nan  = nx || ny || (ix && zy) || (iy && zx);
        e.flags.inf  = !e.flags.nan && (ix || iy || e.flags.ovrf);
        e.flags.zer  = !e.flags.nan && !e.flags.inf && (zx || zy || e.flags.udrf);
        if (e.flags.nan) begin
            e.bits = `FP_QNAN;
        end else if (e.flags.inf) begin
            e.bits = {s, 8'hff, 23'd0};
        end else if (e.flags.zer) begin
            e.bits = {s, 31'd0};
        end else begin
            e.bits = {s, ex[7:0], f[22:0]};
        end
        return e;
    endfunction

    // Normal operand with a mid-range exponent and random sign
    function automatic logic [31:0] rand_normal();
        logic [31:0] r;
        logic [7:0]  e;
        r = $random(seed);
        e = 8'd80 + (r[30:23] % 8'd96);
        return {r[31], e, r[22:0]};
    endfunction

    // Four-phase transfer, req kept high for hold cycles after ack
    task automatic mul_request(input logic [31:0] x, input logic [31:0] y,
                               input round_mode_e rm, input int hold);
        int cycles;
        cycles    = 0;
        op.x.bits = x;
        op.y.bits = y;
        op.rmode  = rm;
        req       = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < 4 * LATENCY);
        // First rising edge that sees req is cycle zero
        if (!ack) begin
            $display("ack never rose within %0d cycles of req", cycles);
            tb_errors++;
        end else if (cycles - 1 != LATENCY) begin
            $display("FAIL %0t: ack after %0d cycles, expected %0d", $time, cycles - 1, LATENCY);
            tb_errors++;
        end
        got_bits  = result.bits;
        got_flags = flags;
        repeat (hold) begin
            @(negedge clk);
            if (!ack || result.bits != got_bits || flags != got_flags) begin
                $display("FAIL %0t: outputs moved while req was held", $time);
                tb_errors++;
            end
        end
        req = 1'b0;
        @(negedge clk);
        if (ack) begin
            $display("FAIL %0t: ack still high one cycle after req fell", $time);
            tb_errors++;
        end
    endtask

    task automatic compare_with_model(input logic [31:0] x, input logic [31:0] y,
                                      input round_mode_e rm);
        expect_t e;
        e = model_mul(x, y, rm);
        mul_request(x, y, rm, 0);
        if (got_bits != e.bits || got_flags != e.flags) begin
            $display("FAIL %0t: %h * %h mode %0d gave %h/%b, expected %h/%b", $time,
                     x, y, rm, got_bits, got_flags, e.bits, e.flags);
            tb_errors++;
        end
    endtask

    // Model check plus a hand-worked word and flag set
    task automatic worked_example(input logic [31:0] x, input logic [31:0] y,
                                  input round_mode_e rm,
                                  input logic [31:0] want, input fp_flags_t want_flags);
        compare_with_model(x, y, rm);
        if (got_bits != want || got_flags != want_flags) begin
            $display("FAIL %0t: %h * %h gave %h/%b, worked value %h/%b", $time,
                     x, y, got_bits, got_flags, want, want_flags);
            tb_errors++;
        end
    endtask

    task automatic normal_products();
        worked_example(32'h40400000, 32'h40400000, RM_RNE, 32'h41100000, FL_NONE);
        repeat (200) begin
            compare_with_model(rand_normal(), rand_normal(), RM_RNE);
        end
    endtask

    task automatic rounding_modes();
        logic [31:0] xs [$];
        logic [31:0] ys [$];
        repeat (40) begin
            xs.push_back(rand_normal());
            ys.push_back(rand_normal());
        end
        // 1.5 times 1+ulp is a tie on an odd fraction, times 1+3ulp on an even one
        xs.push_back(32'h3fc00000);
        ys.push_back(32'h3f800001);
        xs.push_back(32'hbfc00000);
        ys.push_back(32'h3f800003);
        // Just under 2.0, rounding up carries into the exponent
        xs.push_back(32'h3ffffffe);
        ys.push_back(32'h3f800001);
        xs.push_back(32'hbffffffe);
        ys.push_back(32'h3f800001);
        for (int m = 0; m < 5; m++) begin
            foreach (xs[i]) begin
                compare_with_model(xs[i], ys[i], round_mode_e'(m));
            end
        end
        worked_example(32'h3fc00000, 32'h3f800001, RM_RNE, 32'h3fc00002, FL_NONE);
        worked_example(32'h3fc00000, 32'h3f800003, RM_RNE, 32'h3fc00004, FL_NONE);
        worked_example(32'h3ffffffe, 32'h3f800001, RM_RNE, 32'h40000000, FL_NONE);
        worked_example(32'h3ffffffe, 32'h3f800001, RM_RTZ, 32'h3fffffff, FL_NONE);
        worked_example(32'hbffffffe, 32'h3f800001, RM_RDN, 32'hc0000000, FL_NONE);
    endtask

    task automatic zero_operands();
        worked_example(32'h00000000, 32'h40400000, RM_RNE, 32'h00000000, FL_ZER);
        worked_example(32'h80000000, 32'h40400000, RM_RNE, 32'h80000000, FL_ZER);
        // Subnormals flush to zero
        worked_example(32'h00000001, 32'hc0000000, RM_RNE, 32'h80000000, FL_ZER);
        worked_example(32'h807fffff, 32'hc0400000, RM_RUP, 32'h00000000, FL_ZER);
        worked_example(32'h00000000, 32'h00000000, RM_RNE, 32'h00000000, FL_ZER);
    endtask

    task automatic inf_nan_operands();
        worked_example(32'h7f800000, 32'hc0400000, RM_RNE, 32'hff800000, FL_INF);
        worked_example(32'hff800000, 32'hff800000, RM_RNE, 32'h7f800000, FL_INF);
        worked_example(32'h7fc00001, 32'h40400000, RM_RNE, `FP_QNAN, FL_NAN);
        worked_example(32'h40400000, 32'hffffffff, RM_RMM, `FP_QNAN, FL_NAN);
        worked_example(32'h7f800000, 32'h00000000, RM_RNE, `FP_QNAN, FL_NAN);
        worked_example(32'h80000000, 32'hff800000, RM_RTZ, `FP_QNAN, FL_NAN);
    endtask

    task automatic range_limits();
        worked_example(32'h7f000000, 32'h7f000000, RM_RNE, 32'h7f800000, FL_OVF);
        worked_example(32'hff000000, 32'h7f000000, RM_RTZ, 32'hff800000, FL_OVF);
        // 2^64 squared lands exactly on the all-ones exponent
        worked_example(32'h5f800000, 32'h5f800000, RM_RNE, 32'h7f800000, FL_OVF);
        worked_example(32'h00800000, 32'h00800000, RM_RNE, 32'h00000000, FL_UDF);
        worked_example(32'h80800000, 32'h00800000, RM_RNE, 32'h80000000, FL_UDF);
        // Exponent sum of exactly zero
        worked_example(32'h20000000, 32'h1f800000, RM_RNE, 32'h00000000, FL_UDF);
    endtask

    task automatic handshake_and_hold();
        mul_request(32'h40400000, 32'hc0400000, RM_RNE, 6);
        if (got_bits != 32'hc1100000) begin
            $display("FAIL %0t: held request gave %h, expected c1100000", $time, got_bits);
            tb_errors++;
        end
        compare_with_model(32'h3f800000, 32'h3f800000, RM_RNE);
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        op  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (ack !== 1'b0 || result.bits !== '0 || flags !== '0) begin
            $display("FAIL %0t: outputs not cleared by reset", $time);
            tb_errors++;
        end
        handshake_and_hold();
        normal_products();
        rounding_modes();
        zero_operands();
        inf_nan_operands();
        range_limits();
        $display("Errors: %0d testbench, %0d stage checker", tb_errors, chk_errors);
        if (tb_errors == 0 && chk_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/fp_format_pkg.sv
hw/fpmul_stage_pkg.sv
hw/booth_step_counter.sv
hw/fpmul_control.sv
hw/booth_multiplier.sv
hw/fpmul_normalize_round.sv
hw/fpmul_exponent.sv
hw/fp_multiplier.sv
verification/fp_mul_checker.sv
verification/fp_mul_tb.sv

/* Makefile */
TOP := fp_mul_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
